// File: project.f
+incdir+verification
src/fpAddPkg.sv
src/fpOperandAlign.sv
src/fpMantissaAdder.sv
src/fpNormalizer.sv
src/fpResultPack.sv
src/fpAddUnit.sv
verification/fpAddUnitTb.sv

// File: src/fpAddPkg.sv
// shared word, exponent, fraction and shift types, operation codes, fixed-point exponent
package fpAddPkg;

	// 64-bit operand or result, double or signed integer
	typedef logic [63:0] fpWord;

	// biased IEEE double exponent
	typedef logic [10:0] fpExp;

	// exponent with borrow / overflow bit on top
	typedef logic [11:0] fpExpWide;

	// working fraction
	// bit 63 carry guard, bit 62 hidden one, bits 61..10 stored fraction
	typedef logic [63:0] fpFrac;

	// shift amount, top bit shifts everything out
	typedef logic [7:0] fpShift;

	// operation code
	typedef logic [2:0] fpOp;

	localparam fpOp opNop        = 3'd0;
	localparam fpOp opAdd        = 3'd1;
	localparam fpOp opSub        = 3'd2;
	localparam fpOp opIntToFloat = 3'd3;
	localparam fpOp opFloatToInt = 3'd4;

	// bias 1023 plus 62, the fraction then reads as an integer
	localparam fpExp fixedPointExp = 11'd1085;

endpackage

// File: src/fpAddUnit.sv
// top level of the four-stage double-precision add unit
`timescale 1ns/1ns

module fpAddUnit
(
	input  logic clock,
	input  logic rst,
	input  logic hold,
	input  fpAddPkg::fpWord opA,
	input  fpAddPkg::fpWord opB,
	input  fpAddPkg::fpOp op,
	output fpAddPkg::fpWord result,
	output logic done
);
	// stage 1 to stage 2
	logic alignValid;
	fpAddPkg::fpOp alignOp;
	logic bigSign;
	logic smallSign;
	fpAddPkg::fpExp bigExp;
	fpAddPkg::fpFrac bigFrac;
	fpAddPkg::fpFrac smallFrac;
	fpAddPkg::fpWord intMag;
	logic intSign;

	// stage 2 to stage 3
	logic sumValid;
	fpAddPkg::fpOp sumOp;
	logic sumSign;
	fpAddPkg::fpExp sumExp;
	fpAddPkg::fpFrac sumFrac;
	fpAddPkg::fpWord sumRaw;

	// stage 3 to stage 4
	logic normValid;
	fpAddPkg::fpOp normOp;
	logic normSign;
	fpAddPkg::fpExpWide normExp;
	fpAddPkg::fpFrac normFrac;
	fpAddPkg::fpShift normShift;
	fpAddPkg::fpWord normRaw;

	fpOperandAlign i_align (.clock, .rst, .hold, .opA, .opB, .op, .alignValid, .alignOp,
		.bigSign, .smallSign, .bigExp, .bigFrac, .smallFrac, .intMag, .intSign);

	fpMantissaAdder i_adder (.clock, .rst, .hold, .alignValid, .alignOp, .bigSign,
		.smallSign, .bigExp, .bigFrac, .smallFrac, .intMag, .intSign, .sumValid, .sumOp,
		.sumSign, .sumExp, .sumFrac, .sumRaw);

	fpNormalizer i_norm (.clock, .rst, .hold, .sumValid, .sumOp, .sumSign, .sumExp,
		.sumFrac, .sumRaw, .normValid, .normOp, .normSign, .normExp, .normFrac,
		.normShift, .normRaw);

	fpResultPack i_pack (.clock, .rst, .hold, .normValid, .normOp, .normSign, .normExp,
		.normFrac, .normShift, .normRaw, .result, .done);

endmodule

// File: src/fpMantissaAdder.sv
// stage 2 of the add unit: fraction add or subtract, sign fix on borrow, integer magnitude
`timescale 1ns/1ns

module fpMantissaAdder
(
	input  logic clock,
	input  logic rst,
	input  logic hold,
	input  logic alignValid,
	input  fpAddPkg::fpOp alignOp,
	input  logic bigSign,
	input  logic smallSign,
	input  fpAddPkg::fpExp bigExp,
	input  fpAddPkg::fpFrac bigFrac,
	input  fpAddPkg::fpFrac smallFrac,
	input  fpAddPkg::fpWord intMag,
	input  logic intSign,
	output logic sumValid,
	output fpAddPkg::fpOp sumOp,
	output logic sumSign,
	output fpAddPkg::fpExp sumExp,
	output fpAddPkg::fpFrac sumFrac,
	output fpAddPkg::fpWord sumRaw
);
	logic signsDiffer;
	fpAddPkg::fpFrac addA;
	fpAddPkg::fpFrac addB;
	logic carryIn;
	logic [64:0] addOut;
	logic signC;
	fpAddPkg::fpFrac fracC;

	always_comb
	begin
		signsDiffer = (bigSign != smallSign);

		// subtract as invert plus carry-in
		addA = bigFrac;
		addB = signsDiffer ? ~smallFrac : smallFrac;
		carryIn = signsDiffer;

		// int to float finishes the negation of the magnitude
		if (alignOp == fpAddPkg::opIntToFloat)
		begin
			addA = intMag;
			addB = '0;
			carryIn = intSign;
		end

		addOut = {1'b0, addA} + {1'b0, addB} + 65'(carryIn);

		signC = bigSign;
		fracC = addOut[63:0];
		if (alignOp == fpAddPkg::opIntToFloat)
		begin
			signC = intSign;
		end
		else if (signsDiffer && !addOut[64])
		begin
			// borrow, so the smaller operand won: negate and flip sign
			signC = !bigSign;
			fracC = ~addOut[63:0] + 64'd1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			sumValid <= 1'b0;
		end
		else if (!hold)
		begin
			sumValid <= alignValid;
		end

		if (!hold)
		begin
			sumOp <= alignOp;
			sumSign <= signC;
			sumExp <= bigExp;
			sumFrac <= fracC;
			sumRaw <= addOut[63:0];
		end
	end

endmodule

// File: src/fpNormalizer.sv
// add unit stage 3 with leading-zero count, exponent correction and underflow flush
`timescale 1ns/1ns

module fpNormalizer
(
	input  logic clock,
	input  logic rst,
	input  logic hold,
	input  logic sumValid,
	input  fpAddPkg::fpOp sumOp,
	input  logic sumSign,
	input  fpAddPkg::fpExp sumExp,
	input  fpAddPkg::fpFrac sumFrac,
	input  fpAddPkg::fpWord sumRaw,
	output logic normValid,
	output fpAddPkg::fpOp normOp,
	output logic normSign,
	output fpAddPkg::fpExpWide normExp,
	output fpAddPkg::fpFrac normFrac,
	output fpAddPkg::fpShift normShift,
	output fpAddPkg::fpWord normRaw
);
	logic [6:0] leadZeros;
	logic isZero;
	logic signC;
	fpAddPkg::fpExpWide expC;
	fpAddPkg::fpFrac fracC;
	fpAddPkg::fpShift shiftC;

	// 64 when the value is all zero
	function automatic logic [6:0] countLeadingZeros(input fpAddPkg::fpFrac value);
		logic [6:0] count;
		count = 7'd64;
		for (int i = 0; i < 64; i++)
		begin
			if (value[i])
			begin
				count = 7'(63 - i);
			end
		end
		return count;
	endfunction

	always_comb
	begin
		// count below the guard bit
		leadZeros = countLeadingZeros({sumFrac[62:0], 1'b0});
		signC = sumSign;
		fracC = sumFrac;

		if (sumFrac[63])
		begin
			// carry out shifts one step right
			expC = {1'b0, sumExp} + 12'd1;
			fracC = {1'b0, sumFrac[63:1]};
			isZero = 1'b0;
			shiftC = '0;
		end
		else
		begin
			expC = {1'b0, sumExp} - {5'b0, leadZeros};
			// exponent zero or below is a subnormal result
			isZero = leadZeros[6] || expC[11] || (expC == '0);
			shiftC = {isZero, leadZeros};
			if (isZero)
			begin
				signC = 1'b0;
				expC = '0;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			normValid <= 1'b0;
		end
		else if (!hold)
		begin
			normValid <= sumValid;
		end

		if (!hold)
		begin
			normOp <= sumOp;
			normSign <= signC;
			normExp <= expC;
			normFrac <= fracC;
			normShift <= shiftC;
			normRaw <= sumRaw;
		end
	end

	// a valid non-zero result lands its leading one on the hidden bit and none on the guard
	hiddenBitSet: assert property (@(posedge clock) disable iff (rst)
		(normValid && !normShift[7]) |-> (((normFrac << normShift[6:0]) >> 62) == 64'd1));

endmodule

// File: src/fpOperandAlign.sv
// stage 1 of the add unit: unpack, conversion setup, exponent compare, swap, right align
`timescale 1ns/1ns

module fpOperandAlign
(
	input  logic clock,
	input  logic rst,
	input  logic hold,
	input  fpAddPkg::fpWord opA,
	input  fpAddPkg::fpWord opB,
	input  fpAddPkg::fpOp op,
	output logic alignValid,
	output fpAddPkg::fpOp alignOp,
	output logic bigSign,
	output logic smallSign,
	output fpAddPkg::fpExp bigExp,
	output fpAddPkg::fpFrac bigFrac,
	output fpAddPkg::fpFrac smallFrac,
	output fpAddPkg::fpWord intMag,
	output logic intSign
);
	logic isIntToFloat;
	logic isFloatToInt;
	logic signA;
	logic signB;
	fpAddPkg::fpExp expA;
	fpAddPkg::fpExp expB;
	fpAddPkg::fpFrac fracA;
	fpAddPkg::fpFrac fracB;
	fpAddPkg::fpWord intMagC;
	fpAddPkg::fpExpWide diffAB;
	fpAddPkg::fpExpWide diffBA;
	logic useB;
	fpAddPkg::fpFrac shiftIn;
	fpAddPkg::fpShift shiftAmt;
	fpAddPkg::fpFrac shiftOut;

	always_comb
	begin
		isIntToFloat = (op == fpAddPkg::opIntToFloat);
		isFloatToInt = (op == fpAddPkg::opFloatToInt);

		// subtract just flips the sign of opB
		signA = opA[63];
		signB = opB[63] ^ (op == fpAddPkg::opSub);
		expA = opA[62:52];
		expB = opB[62:52];

		// subnormals flush to zero
		fracA = (expA != '0) ? {2'b01, opA[51:0], 10'b0} : '0;
		fracB = (expB != '0) ? {2'b01, opB[51:0], 10'b0} : '0;

		// one's complement magnitude, the +1 is added in stage 2
		intMagC = opA[63] ? ~opA : opA;

		// both conversions run against a zero at the fixed-point exponent
		if (isIntToFloat || isFloatToInt)
		begin
			signB = 1'b0;
			expB = fpAddPkg::fixedPointExp;
			fracB = '0;
		end

		if (isIntToFloat)
		begin
			signA = opA[63];
			expA = fpAddPkg::fixedPointExp;
			fracA = intMagC;
		end

		diffAB = {1'b0, expA} - {1'b0, expB};
		diffBA = {1'b0, expB} - {1'b0, expA};

		// float to int always shifts opA down to integer position
		useB = diffAB[11] || isFloatToInt;
		shiftIn = useB ? fracA : fracB;
		shiftAmt = useB ? {diffBA[10:7] != '0, diffBA[6:0]} : {diffAB[10:7] != '0, diffAB[6:0]};

		// saturating right shift
		shiftOut = shiftAmt[7] ? '0 : (shiftIn >> shiftAmt[6:0]);
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			alignValid <= 1'b0;
		end
		else if (!hold)
		begin
			alignValid <= (op != fpAddPkg::opNop);
		end

		if (!hold)
		begin
			alignOp <= op;
			bigSign <= useB ? signB : signA;
			smallSign <= useB ? signA : signB;
			bigExp <= useB ? expB : expA;
			bigFrac <= useB ? fracB : fracA;
			smallFrac <= shiftOut;
			intMag <= intMagC;
			intSign <= opA[63];
		end
	end

	shiftKnown: assert property (@(posedge clock) disable iff (rst)
		(!hold && op != fpAddPkg::opNop) |-> !$isunknown(shiftAmt));

endmodule

// File: src/fpResultPack.sv
// add unit stage 4 with left shift, double packing or integer select and the result register
`timescale 1ns/1ns

module fpResultPack
(
	input  logic clock,
	input  logic rst,
	input  logic hold,
	input  logic normValid,
	input  fpAddPkg::fpOp normOp,
	input  logic normSign,
	input  fpAddPkg::fpExpWide normExp,
	input  fpAddPkg::fpFrac normFrac,
	input  fpAddPkg::fpShift normShift,
	input  fpAddPkg::fpWord normRaw,
	output fpAddPkg::fpWord result,
	output logic done
);
	fpAddPkg::fpFrac fracShl;
	fpAddPkg::fpWord packWord;

	always_comb
	begin
		// top shift bit clears the fraction
		fracShl = normShift[7] ? '0 : (normFrac << normShift[6:0]);
		packWord = {normSign, normExp[10:0], fracShl[61:10]};

		// float to int returns the raw adder word
		if (normOp == fpAddPkg::opFloatToInt)
		begin
			packWord = normRaw;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			done <= 1'b0;
		end
		else if (!hold)
		begin
			done <= normValid;
		end

		if (!hold)
		begin
			result <= packWord;
		end
	end

	doneKnown: assert property (@(posedge clock) disable iff (rst) !$isunknown(done));

endmodule

// File: verification/fpAddChecks.svh
// expected-value helpers, result scoreboard checks and concurrent hold and reset checks
`ifndef FP_ADD_CHECKS_SVH
`define FP_ADD_CHECKS_SVH

// float to int reference, truncation toward zero
function automatic longint truncToZero(input real value);
	longint nearest;
	nearest = longint'(value);
	if (value >= 0.0 && real'(nearest) > value)
	begin
		nearest = nearest - 1;
	end
	else if (value < 0.0 && real'(nearest) < value)
	begin
		nearest = nearest + 1;
	end
	return nearest;
endfunction

// oldest outstanding operation against a counted result
task automatic checkResult(input fpAddPkg::fpWord actual);
	fpAddPkg::fpWord expected;
	longint issuedAt;
	string testName;
	if (expectQ.size() == 0)
	begin
		$display("done was raised with no operation in flight in test %s", currentTest);
		errorCount++;
	end
	else
	begin
		expected = expectQ.pop_front();
		issuedAt = issueQ.pop_front();
		testName = nameQ.pop_front();
		checkCount++;
		resultMatch: assert (actual === expected)
		else
		begin
			$display("ERROR %s expected %h actual %h", testName, expected, actual);
			errorCount++;
		end
		// four non-held edges from sample to counted done
		latencyFour: assert (edgeCount - issuedAt == 4)
		else
		begin
			$display("result in test %s came %0d edges after its operation instead of 4",
				testName, edgeCount - issuedAt);
			errorCount++;
		end
	end
endtask

task automatic checkNoDone();
	noDoneYet: assert (done === 1'b0)
	else
	begin
		$display("done went high in test %s before any operation was issued", currentTest);
		errorCount++;
	end
endtask

holdFreeze: assert property (@(posedge clock) disable iff (rst)
	$past(hold) |-> ($stable(result) && $stable(done)))
else
begin
	$display("result or done changed across an edge where hold was high");
	errorCount++;
end

doneClearedByReset: assert property (@(posedge clock) rst |=> !done)
else
begin
	$display("done was not cleared by reset");
	errorCount++;
end

`endif

// File: verification/fpAddUnitTb.sv
// testbench for the double-precision add unit with clock, reset, stimulus, scoreboard and report
`timescale 1ns/1ns

module fpAddUnitTb;

	logic clock = 1'b0;
	logic rst;
	logic hold;
	fpAddPkg::fpWord opA;
	fpAddPkg::fpWord opB;
	fpAddPkg::fpOp op;
	fpAddPkg::fpWord result;
	logic done;

	// scoreboard holds one entry per accepted operation
	fpAddPkg::fpWord expectQ[$];
	longint issueQ[$];
	string nameQ[$];
	fpAddPkg::fpWord pendExpect;
	string currentTest;
	longint edgeCount;
	int checkCount;
	int errorCount;
	int checksAtStart;
	int errorsAtStart;
	int seed;
	logic holdRandom;

	`include "fpAddChecks.svh"

	fpAddUnit i_dut (.clock, .rst, .hold, .opA, .opB, .op, .result, .done);

	always #2 clock = ~clock;

	// counts non-held edges, logs accepted operations, checks counted results
	always @(posedge clock)
	begin
		if (rst)
		begin
			edgeCount = 0;
		end
		else if (!hold)
		begin
			edgeCount++;
			if (done)
			begin
				checkResult(result);
			end
			if (op != fpAddPkg::opNop)
			begin
				expectQ.push_back(pendExpect);
				issueQ.push_back(edgeCount);
				nameQ.push_back(currentTest);
			end
		end
	end

	// signed integer below 2^49 in magnitude with a random width
	function automatic longint randomInt();
		longint raw;
		int width;
		raw[63:32] = $random(seed);
		raw[31:0] = $random(seed);
		width = 1 + ({$random(seed)} % 49);
		raw = raw & ((longint'(1) << width) - 1);
		if ($random(seed) & 1)
		begin
			raw = -raw;
		end
		return raw;
	endfunction

	function automatic logic drawHold();
		return holdRandom && (({$random(seed)} % 3) == 0);
	endfunction

	// present one operation and keep it until an edge without hold takes it
	task automatic sendOp(input fpAddPkg::fpOp code, input fpAddPkg::fpWord a,
		input fpAddPkg::fpWord b, input fpAddPkg::fpWord expected);
		int tries;
		logic held;
		op <= code;
		opA <= a;
		opB <= b;
		pendExpect <= expected;
		hold <= drawHold();
		tries = 0;
		held = 1'b1;
		while (held && tries < 64)
		begin
			@(posedge clock);
			held = hold;
			if (held)
			begin
				hold <= drawHold();
			end
			tries++;
		end
		if (held)
		begin
			$display("timeout: an operation in test %s was never accepted", currentTest);
			errorCount++;
		end
	endtask

	task automatic sendAddSub(input real a, input real b, input logic isSub);
		real expected;
		expected = isSub ? a - b : a + b;
		sendOp(isSub ? fpAddPkg::opSub : fpAddPkg::opAdd, $realtobits(a), $realtobits(b),
			$realtobits(expected));
	endtask

	task automatic sendIntToFloat(input longint value);
		sendOp(fpAddPkg::opIntToFloat, value, '0, $realtobits(real'(value)));
	endtask

	task automatic sendFloatToInt(input real value);
		sendOp(fpAddPkg::opFloatToInt, $realtobits(value), '0, truncToZero(value));
	endtask

	task automatic sendRandomOp();
		case ({$random(seed)} % 4)
			0: sendAddSub(real'(randomInt()), real'(randomInt()), 1'b0);
			1: sendAddSub(real'(randomInt()), real'(randomInt()), 1'b1);
			2: sendIntToFloat(randomInt());
			default: sendFloatToInt(real'(randomInt()) * 0.25);
		endcase
	endtask

	task automatic startTest(input string name);
		currentTest = name;
		checksAtStart = checkCount;
		errorsAtStart = errorCount;
	endtask

	// drain the pipeline, then report the test
	task automatic finishTest();
		int waited;
		op <= fpAddPkg::opNop;
		@(negedge clock);
		waited = 0;
		while (expectQ.size() != 0 && waited < 200)
		begin
			@(posedge clock);
			hold <= drawHold();
			@(negedge clock);
			waited++;
		end
		@(posedge clock);
		hold <= 1'b0;
		if (expectQ.size() != 0)
		begin
			$display("timeout: %0d results of test %s never arrived", expectQ.size(),
				currentTest);
			errorCount++;
			expectQ.delete();
			issueQ.delete();
			nameQ.delete();
		end
		$display("%s: %0d results checked, %0d errors", currentTest,
			checkCount - checksAtStart, errorCount - errorsAtStart);
	endtask

	initial
	begin
		seed = 83;
		rst = 1'b1;
		hold = 1'b0;
		op = fpAddPkg::opNop;
		opA = '0;
		opB = '0;
		pendExpect = '0;
		holdRandom = 1'b0;
		checkCount = 0;
		errorCount = 0;
		currentTest = "reset";
		repeat (4) @(posedge clock);
		rst <= 1'b0;

		startTest("resetNop");
		repeat (8)
		begin
			sendOp(fpAddPkg::opNop, randomInt(), randomInt(), '0);
			checkNoDone();
		end
		finishTest();

		startTest("addSub");
		sendAddSub(1.5, 2.25, 1'b0);
		sendAddSub(3.0, 7.75, 1'b1);
		sendAddSub(0.25, 1099511627776.0, 1'b0);
		sendAddSub(-1024.5, 0.125, 1'b1);
		// equal exponents, one borrowing and one carrying out
		sendAddSub(5.0, 6.5, 1'b1);
		sendAddSub(6.5, 5.0, 1'b0);
		repeat (40)
		begin
			sendAddSub(real'(randomInt()), real'(randomInt()), $random(seed) & 1);
		end
		finishTest();

		startTest("zeroResult");
		repeat (6)
		begin
			real value;
			value = real'(randomInt());
			sendAddSub(value, value, 1'b1);
			sendAddSub(value, -value, 1'b0);
		end
		finishTest();

		startTest("convert");
		sendIntToFloat(0);
		sendIntToFloat(-1);
		sendFloatToInt(-7.75);
		sendFloatToInt(7.75);
		sendFloatToInt(-0.5);
		repeat (20)
		begin
			sendIntToFloat(randomInt());
			sendFloatToInt(real'(randomInt()));
			sendFloatToInt(real'(randomInt()) * 0.25);
		end
		finishTest();

		startTest("backToBack");
		repeat (32) sendRandomOp();
		finishTest();

		startTest("randomHold");
		holdRandom = 1'b1;
		repeat (48) sendRandomOp();
		finishTest();
		holdRandom = 1'b0;

		$display("6 tests, %0d results checked, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("TEST PASS");
		end
		else
		begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
